/* rtl/ecc_mem_pkg.sv */
`default_nettype none

package ecc_mem_pkg;

    localparam int DATA_W   = 29;                // payload bits per word.
    localparam int PARITY_W = 7;
    localparam int CODE_W   = DATA_W + PARITY_W; // stored word.
    localparam int AXIL_W   = 32;

    typedef logic [DATA_W-1:0]   ecc_data_t;
    typedef logic [PARITY_W-1:0] ecc_parity_t;   // check field or syndrome.
    typedef logic [CODE_W-1:0]   ecc_code_t;     // {parity, data}.

    typedef logic [AXIL_W-1:0]   axil_data_t;
    typedef logic [AXIL_W/8-1:0] axil_strb_t;
    typedef logic [1:0]          axil_resp_t;

    // byte offset inside the register region.
    typedef logic [4:0]          reg_off_t;

    // two saturating error counters share STATUS.
    typedef logic [15:0]         err_cnt_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    localparam reg_off_t REG_CTRL       = 5'h00; // bit 0 is the global bypass.
    localparam reg_off_t REG_INJ_DATA   = 5'h04;
    localparam reg_off_t REG_INJ_PARITY = 5'h08;
    localparam reg_off_t REG_STATUS     = 5'h0C; // {double count, single count}.
    localparam reg_off_t REG_ERR_ADDR   = 5'h10;

endpackage

`default_nettype wire

/* rtl/ecc_29_cal.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_29_cal (
    input  ecc_mem_pkg::ecc_data_t   data_in,
    input  ecc_mem_pkg::ecc_parity_t parity_in,
    input  logic                     bypass,
    output ecc_mem_pkg::ecc_data_t   data_out,
    output ecc_mem_pkg::ecc_parity_t parity_out,
    output ecc_mem_pkg::ecc_data_t   mask,
    output logic                     sbit_err,
    output logic                     dbit_err
);

    // check-bit column of each data bit with p6 on the left.
    localparam ecc_mem_pkg::ecc_parity_t COLUMN [ecc_mem_pkg::DATA_W] = '{
        7'b1000011, 7'b1000101, 7'b1000110, 7'b0000111,
        7'b1001001, 7'b1001010, 7'b0001011, 7'b1001100,
        7'b0001101, 7'b0001110, 7'b1001111, 7'b1010001,
        7'b1010010, 7'b0010011, 7'b1010100, 7'b0010101,
        7'b0010110, 7'b1010111, 7'b1011000, 7'b0011001,
        7'b0011010, 7'b1011011, 7'b0011100, 7'b1011101,
        7'b1011110, 7'b0011111, 7'b1100001, 7'b1100010,
        7'b0100011
    };

    ecc_mem_pkg::ecc_parity_t syndrome;
    logic                     data_hit;
    logic                     check_hit;

    // parity is the xor of the columns of all set data bits.
    always_comb begin
        parity_out = '0;
        for (int i = 0; i < ecc_mem_pkg::DATA_W; i++) begin
            parity_out = parity_out ^ (COLUMN[i] & {ecc_mem_pkg::PARITY_W{data_in[i]}});
        end
    end

    assign syndrome = parity_in ^ parity_out;

    // columns are distinct, so at most one bit of the mask is set.
    always_comb begin
        mask     = '0;
        data_hit = 1'b0;
        for (int i = 0; i < ecc_mem_pkg::DATA_W; i++) begin
            if (syndrome == COLUMN[i]) begin
                mask[i]  = 1'b1;
                data_hit = 1'b1;
            end
        end
    end

    // a lone syndrome bit points at a flipped check bit.
    assign check_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && (data_hit || check_hit);
    assign dbit_err = !bypass && (syndrome != '0) && !data_hit && !check_hit;

    always_comb begin
        a_one_hit: assert ($onehot0(mask))
            else $error("ecc_29_cal: syndrome matches more than one data column.");
    end

endmodule

`default_nettype wire

/* rtl/ecc_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_ram #(
    parameter int MEM_ADDR_W = 6
) (
    input  logic                   clk,
    input  logic                   we,
    input  logic                   re,
    input  logic [MEM_ADDR_W-1:0]  addr,
    input  ecc_mem_pkg::ecc_code_t wcode,
    output ecc_mem_pkg::ecc_code_t rcode
);

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    ecc_mem_pkg::ecc_code_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wcode;
        end
    end

    // rcode keeps the last word while re is low.
    always_ff @(posedge clk) begin
        if (re) begin
            rcode <= mem[addr];
        end
    end

    // the slave runs one transaction at a time.
    a_no_we_re: assert property (@(posedge clk) !(we && re))
        else $error("ecc_ram: write and read in the same cycle.");

endmodule

`default_nettype wire

/* rtl/ecc_axil_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_axil_slave #(
    parameter int MEM_ADDR_W = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [MEM_ADDR_W+2:0]    awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  ecc_mem_pkg::axil_data_t  wdata,
    input  ecc_mem_pkg::axil_strb_t  wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output ecc_mem_pkg::axil_resp_t  bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [MEM_ADDR_W+2:0]    araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output ecc_mem_pkg::axil_data_t  rdata,
    output ecc_mem_pkg::axil_resp_t  rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     ram_we,
    output logic                     ram_re,
    output logic [MEM_ADDR_W-1:0]    ram_addr,
    output ecc_mem_pkg::ecc_code_t   ram_wcode,
    input  ecc_mem_pkg::ecc_code_t   ram_rcode
);

    localparam int DATA_W = ecc_mem_pkg::DATA_W;
    localparam int PAD_W  = ecc_mem_pkg::AXIL_W - DATA_W;

    typedef enum logic [2:0] {
        IDLE,
        WRITE,
        READ_WAIT,
        READ_RESP,
        WRITE_RESP
    } state_t;

    state_t                   state;
    logic [MEM_ADDR_W+2:0]    addr_q;
    ecc_mem_pkg::axil_data_t  wdata_q;
    ecc_mem_pkg::axil_strb_t  wstrb_q;
    logic                     bypass_q;
    ecc_mem_pkg::ecc_data_t   inj_data_q;
    ecc_mem_pkg::ecc_parity_t inj_parity_q;
    ecc_mem_pkg::err_cnt_t    sbit_cnt_q;
    ecc_mem_pkg::err_cnt_t    dbit_cnt_q;
    logic [MEM_ADDR_W-1:0]    err_addr_q;

    logic                     wr_accept;
    logic                     rd_accept;
    logic                     is_reg;
    ecc_mem_pkg::reg_off_t    reg_off;
    logic                     full_strb;
    logic                     reg_write;
    logic                     mem_read_done;
    ecc_mem_pkg::ecc_data_t   cal_data_in;
    ecc_mem_pkg::ecc_parity_t cal_parity_in;
    ecc_mem_pkg::ecc_data_t   cal_data_out;
    ecc_mem_pkg::ecc_parity_t cal_parity_out;
    logic                     sbit_err;
    logic                     dbit_err;
    ecc_mem_pkg::axil_data_t  reg_rdata;

    // a write needs both channels and reads wait while any write is offered.
    assign wr_accept = !rst && (state == IDLE) && awvalid && wvalid;
    assign arready   = !rst && (state == IDLE) && !awvalid && !wvalid;
    assign rd_accept = arready && arvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    assign is_reg    = addr_q[MEM_ADDR_W+2];      // top bit selects the region.
    assign reg_off   = addr_q[4:0];
    assign full_strb = (wstrb_q == '1);
    assign reg_write = (state == WRITE) && is_reg;

    assign ram_we   = (state == WRITE) && !is_reg && full_strb;
    assign ram_re   = (state == READ_WAIT) && !is_reg;
    assign ram_addr = addr_q[MEM_ADDR_W+1:2];

    // one encoder/decoder is fed from the write data or the stored word.
    assign cal_data_in   = (state == WRITE) ? wdata_q[DATA_W-1:0] : ram_rcode[DATA_W-1:0];
    assign cal_parity_in = (state == WRITE) ? '0 : ram_rcode[ecc_mem_pkg::CODE_W-1:DATA_W];

    ecc_29_cal ecc_29_cal_i (
        .data_in    (cal_data_in),
        .parity_in  (cal_parity_in),
        .bypass     (bypass_q),
        .data_out   (cal_data_out),
        .parity_out (cal_parity_out),
        .mask       (),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    assign ram_wcode = {cal_parity_out ^ inj_parity_q, wdata_q[DATA_W-1:0] ^ inj_data_q};

    assign bvalid = (state == WRITE_RESP);
    assign rvalid = (state == READ_RESP);
    assign bresp  = (!is_reg && !full_strb) ? ecc_mem_pkg::RESP_SLVERR : ecc_mem_pkg::RESP_OKAY;
    assign rresp  = (!is_reg && dbit_err) ? ecc_mem_pkg::RESP_SLVERR : ecc_mem_pkg::RESP_OKAY;
    assign rdata  = is_reg ? reg_rdata : {{PAD_W{1'b0}}, cal_data_out};

    assign mem_read_done = rvalid && rready && !is_reg;

    always_comb begin
        reg_rdata = '0;
        case (reg_off)
            ecc_mem_pkg::REG_CTRL:       reg_rdata[0] = bypass_q;
            ecc_mem_pkg::REG_INJ_DATA:   reg_rdata[DATA_W-1:0] = inj_data_q;
            ecc_mem_pkg::REG_INJ_PARITY: reg_rdata[ecc_mem_pkg::PARITY_W-1:0] = inj_parity_q;
            ecc_mem_pkg::REG_STATUS:     reg_rdata = {dbit_cnt_q, sbit_cnt_q};
            ecc_mem_pkg::REG_ERR_ADDR:   reg_rdata[MEM_ADDR_W-1:0] = err_addr_q;
            default:                     reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wr_accept) begin
                        state <= WRITE;
                    end else if (rd_accept) begin
                        state <= READ_WAIT;
                    end
                end
                WRITE:      state <= WRITE_RESP;
                READ_WAIT:  state <= READ_RESP;   // ram output lands here.
                WRITE_RESP: state <= bready ? IDLE : WRITE_RESP;
                READ_RESP:  state <= rready ? IDLE : READ_RESP;
                default:    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            addr_q  <= awaddr;
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end else if (rd_accept) begin
            addr_q <= araddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bypass_q     <= 1'b0;
            inj_data_q   <= '0;
            inj_parity_q <= '0;
            sbit_cnt_q   <= '0;
            dbit_cnt_q   <= '0;
            err_addr_q   <= '0;
        end else begin
            if (reg_write) begin
                case (reg_off)
                    ecc_mem_pkg::REG_CTRL:       bypass_q <= wdata_q[0];
                    ecc_mem_pkg::REG_INJ_DATA:   inj_data_q <= wdata_q[DATA_W-1:0];
                    ecc_mem_pkg::REG_INJ_PARITY: inj_parity_q <= wdata_q[ecc_mem_pkg::PARITY_W-1:0];
                    default: ;
                endcase
            end
            if (ram_we) begin
                inj_data_q   <= '0;                 // injection is one-shot.
                inj_parity_q <= '0;
            end
            if (reg_write && (reg_off == ecc_mem_pkg::REG_STATUS)) begin
                sbit_cnt_q <= '0;
                dbit_cnt_q <= '0;
            end else if (mem_read_done) begin
                if (sbit_err && (sbit_cnt_q != '1)) begin
                    sbit_cnt_q <= sbit_cnt_q + 1'b1;
                end
                if (dbit_err && (dbit_cnt_q != '1)) begin
                    dbit_cnt_q <= dbit_cnt_q + 1'b1;
                end
                if (sbit_err || dbit_err) begin
                    err_addr_q <= ram_addr;
                end
            end
        end
    end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("ecc_axil_slave: write address dropped before awready.");

    a_b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("ecc_axil_slave: write response dropped before bready.");

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
        else $error("ecc_axil_slave: read response changed before rready.");

endmodule

`default_nettype wire

/* rtl/ecc_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_top #(
    parameter int MEM_ADDR_W = 6          // log2 of the word depth.
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [MEM_ADDR_W+2:0]    awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  ecc_mem_pkg::axil_data_t  wdata,
    input  ecc_mem_pkg::axil_strb_t  wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output ecc_mem_pkg::axil_resp_t  bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [MEM_ADDR_W+2:0]    araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output ecc_mem_pkg::axil_data_t  rdata,
    output ecc_mem_pkg::axil_resp_t  rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    logic                   ram_we;
    logic                   ram_re;
    logic [MEM_ADDR_W-1:0]  ram_addr;
    ecc_mem_pkg::ecc_code_t ram_wcode;
    ecc_mem_pkg::ecc_code_t ram_rcode;

    ecc_axil_slave #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) ecc_axil_slave_i (
        .clk       (clk),
        .rst       (rst),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .ram_we    (ram_we),
        .ram_re    (ram_re),
        .ram_addr  (ram_addr),
        .ram_wcode (ram_wcode),
        .ram_rcode (ram_rcode)
    );

    ecc_ram #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) ecc_ram_i (
        .clk   (clk),
        .we    (ram_we),
        .re    (ram_re),
        .addr  (ram_addr),
        .wcode (ram_wcode),
        .rcode (ram_rcode)
    );

endmodule

`default_nettype wire

/* include/ecc_tb_model.svh */
`ifndef ECC_TB_MODEL_SVH
`define ECC_TB_MODEL_SVH

// reference check bits use one data-bit mask per parity bit.
function automatic ecc_mem_pkg::ecc_parity_t model_parity(input ecc_mem_pkg::ecc_data_t d);
    ecc_mem_pkg::ecc_parity_t p;
    p[0] = ^(d & 29'h16AAAD5B);
    p[1] = ^(d & 29'h1B33366D);
    p[2] = ^(d & 29'h03C3C78E);
    p[3] = ^(d & 29'h03FC07F0);
    p[4] = ^(d & 29'h03FFF800);
    p[5] = ^(d & 29'h1C000000);
    p[6] = ^(d & 29'h0DA65CB7);
    return p;
endfunction

// returns 0 clean, 1 single, 2 double and the corrected data.
function automatic int model_decode(input ecc_mem_pkg::ecc_data_t d,
                                    input ecc_mem_pkg::ecc_parity_t p,
                                    output ecc_mem_pkg::ecc_data_t fixed);
    ecc_mem_pkg::ecc_parity_t syn;
    syn   = p ^ model_parity(d);
    fixed = d;
    if (syn == '0) return 0;
    if ($onehot(syn)) return 1;
    for (int i = 0; i < ecc_mem_pkg::DATA_W; i++) begin
        if (model_parity(ecc_mem_pkg::ecc_data_t'(1) << i) == syn) begin
            fixed[i] = ~fixed[i];
            return 1;
        end
    end
    return 2;
endfunction

// drivers work on the testbench signals named as the DUT ports.
task automatic axi_write(input int unsigned addr, input ecc_mem_pkg::axil_data_t data,
                         input ecc_mem_pkg::axil_strb_t strb,
                         output ecc_mem_pkg::axil_resp_t resp);
    @(negedge clk);
    awaddr  = addr[$bits(awaddr)-1:0];
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!awready) begin
        @(negedge clk);
        #1;
    end
    check_value("wready at the write handshake", 32'(wready), 32'd1);
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    #1;
    while (!bvalid) begin
        @(negedge clk);
        #1;
    end
    resp = bresp;
    @(negedge clk);
    bready = 1'b0;
endtask

task automatic axi_read(input int unsigned addr, output ecc_mem_pkg::axil_data_t data,
                        output ecc_mem_pkg::axil_resp_t resp);
    @(negedge clk);
    araddr  = addr[$bits(araddr)-1:0];
    arvalid = 1'b1;
    #1;
    while (!arready) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    rready  = 1'b1;
    #1;
    while (!rvalid) begin
        @(negedge clk);
        #1;
    end
    data = rdata;
    resp = rresp;
    @(negedge clk);
    rready = 1'b0;
endtask

`endif

/* sim/ecc_mem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_mem_tb;

    localparam int MEM_ADDR_W = 6;
    localparam int CLK_PERIOD = 8;
    localparam logic [31:0] REG_BASE = 32'h1 << (MEM_ADDR_W + 2); // top address bit.
    localparam int CTRL_OFF   = int'(ecc_mem_pkg::REG_CTRL);
    localparam int INJ_OFF    = int'(ecc_mem_pkg::REG_INJ_DATA);
    localparam int PAR_OFF    = int'(ecc_mem_pkg::REG_INJ_PARITY);
    localparam int STATUS_OFF = int'(ecc_mem_pkg::REG_STATUS);
    localparam int ERR_OFF    = int'(ecc_mem_pkg::REG_ERR_ADDR);
    localparam logic [1:0] OP_MWRITE = 2'd0;
    localparam logic [1:0] OP_MREAD  = 2'd1;
    localparam logic [1:0] OP_RWRITE = 2'd2;
    localparam logic [1:0] OP_RREAD  = 2'd3;

    typedef struct packed {
        logic [1:0]               op;
        logic [31:0]              addr;
        ecc_mem_pkg::axil_data_t  data;
        ecc_mem_pkg::axil_strb_t  strb;
        ecc_mem_pkg::ecc_data_t   inj_data;
        ecc_mem_pkg::ecc_parity_t inj_parity;
        logic                     bypass;
        ecc_mem_pkg::axil_resp_t  exp_resp;
        ecc_mem_pkg::axil_data_t  exp_data;
    } row_t;

    logic                     clk;
    logic                     rst;
    logic [MEM_ADDR_W+2:0]    awaddr;
    logic                     awvalid;
    logic                     awready;
    ecc_mem_pkg::axil_data_t  wdata;
    ecc_mem_pkg::axil_strb_t  wstrb;
    logic                     wvalid;
    logic                     wready;
    ecc_mem_pkg::axil_resp_t  bresp;
    logic                     bvalid;
    logic                     bready;
    logic [MEM_ADDR_W+2:0]    araddr;
    logic                     arvalid;
    logic                     arready;
    ecc_mem_pkg::axil_data_t  rdata;
    ecc_mem_pkg::axil_resp_t  rresp;
    logic                     rvalid;
    logic                     rready;

    // reference state advances while the table is built.
    ecc_mem_pkg::ecc_data_t   model_data [2**MEM_ADDR_W];
    ecc_mem_pkg::ecc_parity_t model_par [2**MEM_ADDR_W];
    ecc_mem_pkg::err_cnt_t    model_scnt;
    ecc_mem_pkg::err_cnt_t    model_dcnt;
    int                       model_err_addr;
    logic                     bld_bypass;
    logic                     cur_bypass;               // CTRL bit 0 as the DUT holds it.
    row_t                     rows [$];
    int                       err_count;
    int                       check_count;
    bit                       table_ready;

    ecc_mem_top #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) ecc_mem_top_i (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

`include "ecc_tb_model.svh"

    function automatic string op_name(input logic [1:0] op);
        case (op)
            OP_MWRITE: return "mem write";
            OP_MREAD:  return "mem read ";
            OP_RWRITE: return "reg write";
            default:   return "reg read ";
        endcase
    endfunction

    // appends one row and moves the model to the state after it.
    task automatic add_row(input logic [1:0] op, input int loc,
                           input ecc_mem_pkg::axil_data_t data,
                           input ecc_mem_pkg::ecc_data_t inj_d,
                           input ecc_mem_pkg::ecc_parity_t inj_p,
                           input ecc_mem_pkg::axil_strb_t strb);
        row_t                   r;
        ecc_mem_pkg::ecc_data_t fixed;
        int                     cls;
        r            = '0;
        r.op         = op;
        r.addr       = (op == OP_MWRITE || op == OP_MREAD) ? (32'(loc) << 2)
                                                           : (REG_BASE | 32'(loc));
        r.data       = data;
        r.strb       = strb;
        r.inj_data   = inj_d;
        r.inj_parity = inj_p;
        r.bypass     = bld_bypass;
        r.exp_resp   = ecc_mem_pkg::RESP_OKAY;
        case (op)
            OP_MWRITE: begin
                if (strb == 4'hF) begin
                    model_data[loc] = data[28:0] ^ inj_d;
                    model_par[loc]  = model_parity(data[28:0]) ^ inj_p;
                end else begin
                    r.exp_resp = ecc_mem_pkg::RESP_SLVERR;  // partial strobe is refused.
                end
            end
            OP_MREAD: begin
                fixed = model_data[loc];
                cls   = 0;
                if (!bld_bypass) begin
                    cls = model_decode(model_data[loc], model_par[loc], fixed);
                end
                r.exp_data = {3'b000, ((cls == 2) ? model_data[loc] : fixed)};
                if (cls == 1 && model_scnt != '1) begin
                    model_scnt = model_scnt + 1'b1;
                end
                if (cls == 2) begin
                    r.exp_resp = ecc_mem_pkg::RESP_SLVERR;
                    if (model_dcnt != '1) begin
                        model_dcnt = model_dcnt + 1'b1;
                    end
                end
                if (cls != 0) begin
                    model_err_addr = loc;
                end
            end
            OP_RWRITE: begin
                if (loc == STATUS_OFF) begin
                    model_scnt = '0;
                    model_dcnt = '0;
                end
            end
            default: begin
                case (loc)
                    CTRL_OFF:   r.exp_data = 32'(bld_bypass);
                    STATUS_OFF: r.exp_data = {model_dcnt, model_scnt};
                    ERR_OFF:    r.exp_data = 32'(model_err_addr);
                    default:    r.exp_data = '0;   // injection is used up by a full write.
                endcase
            end
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        ecc_mem_pkg::axil_data_t keep;
        int                      b0;
        int                      b1;
        for (int k = 0; k < 6; k++) begin
            add_row(OP_MWRITE, k * 7, $urandom(), '0, '0, 4'hF);
        end
        for (int k = 0; k < 6; k++) begin
            add_row(OP_MREAD, k * 7, '0, '0, '0, 4'hF);
        end
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        // one flipped data bit.
        add_row(OP_MWRITE, 9, $urandom(), 29'(1) << $urandom_range(28, 0), '0, 4'hF);
        add_row(OP_MREAD, 9, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, INJ_OFF, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, ERR_OFF, '0, '0, '0, 4'hF);
        // one flipped check bit.
        add_row(OP_MWRITE, 12, $urandom(), '0, 7'(1) << $urandom_range(6, 0), 4'hF);
        add_row(OP_MREAD, 12, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        // two flipped bits as a fixed pair and then a random one.
        b0 = $urandom_range(28, 0);
        b1 = (b0 + 1 + $urandom_range(27, 0)) % 29;
        add_row(OP_MWRITE, 20, $urandom(), 29'h3, '0, 4'hF);
        add_row(OP_MREAD, 20, '0, '0, '0, 4'hF);
        add_row(OP_MWRITE, 33, $urandom(), (29'(1) << b0) | (29'(1) << b1), '0, 4'hF);
        add_row(OP_MREAD, 33, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, ERR_OFF, '0, '0, '0, 4'hF);
        add_row(OP_RWRITE, STATUS_OFF, 32'hFFFF_FFFF, '0, '0, 4'hF);
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        bld_bypass = 1'b1;
        add_row(OP_RREAD, CTRL_OFF, '0, '0, '0, 4'hF);
        add_row(OP_MWRITE, 41, $urandom(), 29'(1) << $urandom_range(28, 0), '0, 4'hF);
        add_row(OP_MREAD, 41, '0, '0, '0, 4'hF);
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        bld_bypass = 1'b0;
        add_row(OP_MREAD, 41, '0, '0, '0, 4'hF);   // the same word is corrected now.
        add_row(OP_RREAD, STATUS_OFF, '0, '0, '0, 4'hF);
        keep = $urandom();
        add_row(OP_MWRITE, 50, keep, '0, '0, 4'hF);
        add_row(OP_MWRITE, 50, ~keep, '0, '0, 4'h3);
        add_row(OP_MREAD, 50, '0, '0, '0, 4'hF);
    endtask

    task automatic apply_row(input row_t r);
        ecc_mem_pkg::axil_resp_t resp;
        ecc_mem_pkg::axil_data_t rd;
        if (r.bypass != cur_bypass) begin
            axi_write(REG_BASE | CTRL_OFF, 32'(r.bypass), 4'hF, resp);
            check_value("ctrl write response", 32'(resp), 32'(ecc_mem_pkg::RESP_OKAY));
            cur_bypass = r.bypass;
        end
        if (r.inj_data != '0) begin
            axi_write(REG_BASE | INJ_OFF, 32'(r.inj_data), 4'hF, resp);
            check_value("inject data write response", 32'(resp), 32'(ecc_mem_pkg::RESP_OKAY));
        end
        if (r.inj_parity != '0) begin
            axi_write(REG_BASE | PAR_OFF, 32'(r.inj_parity), 4'hF, resp);
            check_value("inject parity write response", 32'(resp),
                        32'(ecc_mem_pkg::RESP_OKAY));
        end
        if (r.op == OP_MWRITE || r.op == OP_RWRITE) begin
            axi_write(r.addr, r.data, r.strb, resp);
            check_value("write response", 32'(resp), 32'(r.exp_resp));
        end else begin
            axi_read(r.addr, rd, resp);
            check_value("read response", 32'(resp), 32'(r.exp_resp));
            check_value("read data", rd, r.exp_data);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        int unsigned timeout_ns;
        wait (table_ready);
        timeout_ns = (rows.size() * 50 + 16) * CLK_PERIOD;  // reset cycles on top.
        #(timeout_ns);
        $display("watchdog: the run did not finish within %0d ns", timeout_ns);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int errs_before;
        rst            = 1'b1;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        model_scnt     = '0;
        model_dcnt     = '0;
        model_err_addr = 0;
        bld_bypass     = 1'b0;
        cur_bypass     = 1'b0;
        err_count      = 0;
        check_count    = 0;
        void'($urandom(95511));
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (rows[i]) begin
            errs_before = err_count;
            apply_row(rows[i]);
            $display("row %0d %s addr 0x%03h: %s", i, op_name(rows[i].op), rows[i].addr,
                     (err_count == errs_before) ? "ok" : "mismatch");
        end
        $display("rows %0d, checks %0d, errors %0d", rows.size(), check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+include
rtl/ecc_mem_pkg.sv
rtl/ecc_29_cal.sv
rtl/ecc_ram.sv
rtl/ecc_axil_slave.sv
rtl/ecc_mem_top.sv
sim/ecc_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds ecc_mem_tb with verilator, runs it and scans the log for the fail message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_LOG=build.log

rm -rf obj_dir "$LOG" "$BUILD_LOG"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f project.f --top-module ecc_mem_tb -o ecc_mem_sim > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/ecc_mem_sim > "$LOG" 2>&1 \
    || { cat "$BUILD_LOG" "$LOG" 2>/dev/null; echo "build or simulation error"; exit 1; }

cat "$LOG"
grep -qF '*** FAILED ***' "$LOG" && exit 1
exit 0
